// ==== filelist.f ====
hdl/monitor_char_pkg.sv
hdl/monitor_cmd_pkg.sv
hdl/char_bus_if.sv
hdl/word_bus_if.sv
hdl/char_decoder.sv
hdl/hex_word_collector.sv
hdl/cmd_sequencer.sv
hdl/pc_breakpoint.sv
hdl/uart_monitor_top.sv
tests/uart_monitor_props.sv
tests/uart_monitor_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the UART monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=uart_monitor_tb

verilator --binary --timing --assert -f filelist.f --top-module "$TOP" \
	-Mdir "$BUILD_DIR" -o "sim_$TOP"
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

"./$BUILD_DIR/sim_$TOP"
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation ended with status $status"
	exit "$status"
fi

exit 0

// ==== tests/uart_monitor_tb.sv ====
`timescale 1ns/1ps

module uart_monitor_tb;
	import monitor_char_pkg::*;
	import monitor_cmd_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 3;
	// one enable cycle plus three idle cycles
	localparam int CHAR_CYCLES = 4;
	// characters sent over all directed tests
	localparam int TEST_CHARS = 139;
	localparam int MARGIN_CYCLES = 100;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CHARS * CHAR_CYCLES + MARGIN_CYCLES;

	// index of each output pulse in pulse_vec
	localparam int P_WAS = 0;
	localparam int P_WDE = 1;
	localparam int P_RSS = 2;
	localparam int P_RES = 3;
	localparam int P_STOP = 4;
	localparam int P_QUIT = 5;
	localparam int P_CRLF = 6;
	localparam int P_START = 7;

	logic clk;
	logic rst_n;
	uart_byte_t rout;
	logic rout_en;
	logic dump_running;
	word_t pc_data;
	logic cpu_run_state;
	word_t uart_data;
	logic cpu_start;
	logic write_address_set;
	logic write_data_en;
	logic read_start_set;
	logic read_end_set;
	logic read_stop;
	logic quit_cmd;
	logic crlf_in;

	logic [7:0] pulse_vec;
	int pulse_n [8];
	int pulse_cyc [8];
	word_t pulse_data [8];
	int base_n [8];
	int cyc = 0;
	int char_cyc;
	logic [15:0] lfsr = 16'd8;

	uart_monitor_top u_dut (
		.clk (clk),
		.rst_n (rst_n),
		.rout (rout),
		.rout_en (rout_en),
		.dump_running (dump_running),
		.pc_data (pc_data),
		.cpu_run_state (cpu_run_state),
		.uart_data (uart_data),
		.cpu_start (cpu_start),
		.write_address_set (write_address_set),
		.write_data_en (write_data_en),
		.read_start_set (read_start_set),
		.read_end_set (read_end_set),
		.read_stop (read_stop),
		.quit_cmd (quit_cmd),
		.crlf_in (crlf_in)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	assign pulse_vec = {cpu_start, crlf_in, quit_cmd, read_stop,
		read_end_set, read_start_set, write_data_en, write_address_set};

	// log every pulse mid-cycle, where outputs are settled
	always @(negedge clk) begin
		int i;
		for (i = 0; i < 8; i++) begin
			if (pulse_vec[i]) begin
				pulse_n[i] = pulse_n[i] + 1;
				pulse_cyc[i] = cyc;
				pulse_data[i] = uart_data;
			end
		end
	end

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic word_t rand_word();
		word_t w;
		int i;
		w = '0;
		for (i = 0; i < 32; i++)
			w = {w[30:0], lfsr_step()};
		return w;
	endfunction

	// ascii of a lower case hex digit
	function automatic uart_byte_t hex_char(input nibble_t n);
		if (n < 4'd10)
			return CHAR_ZERO + {4'd0, n};
		else
			return CHAR_LOWER_A + {4'd0, n} - 8'd10;
	endfunction

	function automatic int pulses_since_mark(input int p);
		return pulse_n[p] - base_n[p];
	endfunction

	task automatic mark_counts();
		base_n = pulse_n;
	endtask

	task automatic check_eq(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("Testbench failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// char_cyc ends up holding cycle 0 of this character
	task automatic send_char(input uart_byte_t c);
		@(posedge clk);
		rout <= c;
		rout_en <= 1'b1;
		@(negedge clk);
		char_cyc = cyc;
		@(posedge clk);
		rout_en <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	// most significant digit first
	task automatic send_word(input word_t w);
		int k;
		for (k = 7; k >= 0; k--)
			send_char(hex_char(w[k*4 +: 4]));
	endtask

	task automatic wait_cpu_start();
		int k;
		k = 0;
		while (pulses_since_mark(P_START) == 0 && k < 8) begin
			@(posedge clk);
			k++;
		end
	endtask

	task automatic write_and_quit();
		word_t addr;
		word_t data;
		int k;
		addr = rand_word();
		mark_counts();
		send_char(CHAR_W);
		send_word(addr);
		check_eq(pulses_since_mark(P_WAS), 1, "write address pulse count");
		check_eq(pulse_cyc[P_WAS], char_cyc + 2, "write address timing");
		check_eq(pulse_data[P_WAS], addr, "write address value");
		for (k = 1; k <= 2; k++) begin
			data = rand_word();
			send_word(data);
			check_eq(pulses_since_mark(P_WDE), k, "write data pulse count");
			check_eq(pulse_data[P_WDE], data, "write data value");
		end
		mark_counts();
		send_char(CHAR_CTRL_C);
		check_eq(pulses_since_mark(P_QUIT), 1, "quit after write");
		check_eq(pulses_since_mark(P_CRLF), 1, "line break after write quit");
		check_eq(pulse_cyc[P_QUIT], char_cyc + 1, "quit timing");
	endtask

	task automatic read_and_dump();
		word_t start_addr;
		word_t end_addr;
		start_addr = rand_word();
		end_addr = rand_word();
		@(posedge clk);
		dump_running <= 1'b1;
		mark_counts();
		send_char(CHAR_R);
		send_word(start_addr);
		send_word(end_addr);
		check_eq(pulses_since_mark(P_RSS), 1, "read start pulse count");
		check_eq(pulse_data[P_RSS], start_addr, "read start value");
		check_eq(pulses_since_mark(P_RES), 1, "read end pulse count");
		check_eq(pulse_data[P_RES], end_addr, "read end value");
		mark_counts();
		send_char(CHAR_CTRL_C);
		check_eq(pulses_since_mark(P_STOP), 1, "read stop on quit");
		check_eq(pulse_cyc[P_STOP], char_cyc + 1, "read stop timing");
		check_eq(pulses_since_mark(P_QUIT), 1, "quit during dump");
		// second dump ends when the dump engine finishes
		mark_counts();
		send_char(CHAR_R);
		send_word(rand_word());
		send_word(rand_word());
		check_eq(pulses_since_mark(P_RES), 1, "second read end pulse count");
		@(posedge clk);
		dump_running <= 1'b0;
		@(posedge clk);
		start_addr = rand_word();
		send_char(CHAR_W);
		send_word(start_addr);
		check_eq(pulses_since_mark(P_STOP), 0, "read stop without quit");
		check_eq(pulses_since_mark(P_WAS), 1, "write accepted after dump");
		check_eq(pulse_data[P_WAS], start_addr, "write address after dump");
		send_char(CHAR_CTRL_C);
	endtask

	task automatic go_and_start();
		word_t addr;
		addr = rand_word();
		mark_counts();
		send_char(CHAR_G);
		send_word(addr);
		check_eq(pulses_since_mark(P_CRLF), 1, "go line break count");
		check_eq(pulse_cyc[P_CRLF], char_cyc + 2, "go line break timing");
		check_eq(pulse_data[P_CRLF], addr, "go address value");
		wait_cpu_start();
		check_eq(pulses_since_mark(P_START), 1, "cpu start count");
		check_eq(pulse_cyc[P_START] - pulse_cyc[P_CRLF], START_DELAY, "cpu start delay");
		send_char(CHAR_CTRL_C);
	endtask

	// set s_word, go, then show pc as the running pc for one cycle
	task automatic run_with_breakpoint(input word_t s_word, input word_t pc, output logic hit);
		send_char(CHAR_S);
		send_word(s_word);
		mark_counts();
		send_char(CHAR_G);
		send_word(rand_word());
		wait_cpu_start();
		check_eq(pulses_since_mark(P_START), 1, "cpu start before run");
		@(posedge clk);
		cpu_run_state <= 1'b1;
		pc_data <= pc;
		@(negedge clk);
		hit = quit_cmd;
		@(posedge clk);
		cpu_run_state <= 1'b0;
		pc_data <= '0;
	endtask

	task automatic breakpoint_stop();
		word_t bp;
		logic hit;
		bp = rand_word() & ~32'h3;
		run_with_breakpoint(bp, bp, hit);
		check_eq(word_t'(hit), 1, "quit on breakpoint hit");
		// bit 0 set leaves the breakpoint disarmed
		run_with_breakpoint(bp | 32'h1, bp, hit);
		check_eq(word_t'(hit), 0, "quit with disarmed breakpoint");
		send_char(CHAR_CTRL_C);
	endtask

	task automatic partial_word_restart();
		word_t partial;
		word_t full;
		uart_byte_t junk [5];
		int k;
		junk = '{8'h41, 8'h46, 8'h78, 8'h20, 8'h67};
		partial = rand_word();
		full = rand_word();
		mark_counts();
		send_char(CHAR_W);
		for (k = 0; k < 4; k++)
			send_char(hex_char(partial[k*4 +: 4]));
		send_char(CHAR_CTRL_C);
		send_char(CHAR_W);
		// non-digits between the digits
		for (k = 7; k >= 0; k--) begin
			send_char(hex_char(full[k*4 +: 4]));
			if (k >= 3)
				send_char(junk[7 - k]);
		end
		check_eq(pulses_since_mark(P_WAS), 1, "write address after partial word");
		check_eq(pulse_data[P_WAS], full, "address without leftover digits");
		check_eq(pulses_since_mark(P_QUIT), 1, "quit count with ignored bytes");
		send_char(CHAR_CTRL_C);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Testbench failed");
		$fatal(1, "watchdog expired before the tests finished");
	end

	initial begin
		rst_n = 1'b0;
		rout = '0;
		rout_en = 1'b0;
		dump_running = 1'b0;
		pc_data = '0;
		cpu_run_state = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_eq(uart_data, 0, "uart data after reset");
		check_eq(word_t'(pulse_vec), 0, "strobes after reset");
		write_and_quit();
		read_and_dump();
		go_and_start();
		breakpoint_stop();
		partial_word_restart();
		repeat (4) @(posedge clk);
		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== tests/uart_monitor_props.sv ====
`timescale 1ns/1ps

module uart_monitor_props (
	input logic clk,
	input logic rst_n,
	input monitor_cmd_pkg::cmd_state_t state,
	input logic word_valid,
	input logic take_digit,
	input logic bp_load,
	input logic crlf_in,
	input logic cpu_start,
	input logic quit_cmd,
	input logic read_stop
);
	import monitor_cmd_pkg::*;

	logic go_crlf;

	// line break that closes the go address
	assign go_crlf = crlf_in & word_valid & (state == ST_GO_ADDR);

	idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		(state == ST_IDLE) |-> !(bp_load || take_digit))
		else $error("breakpoint load or digit shift in idle state");

	// start pulse only START_DELAY cycles after the go line break
	start_delay: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_start == $past(go_crlf, START_DELAY))
		else $error("cpu start out of step with the go line break");

	stop_quits: assert property (@(posedge clk) disable iff (!rst_n)
		read_stop |-> quit_cmd)
		else $error("read stop without quit");

endmodule

bind cmd_sequencer uart_monitor_props u_props (
	.clk (clk),
	.rst_n (rst_n),
	.state (state),
	.word_valid (wbus.word_valid),
	.take_digit (wbus.take_digit),
	.bp_load (bp_load),
	.crlf_in (crlf_in),
	.cpu_start (cpu_start),
	.quit_cmd (quit_cmd),
	.read_stop (read_stop)
);

// ==== hdl/uart_monitor_top.sv ====
`timescale 1ns/1ps

module uart_monitor_top (
	input logic clk,
	input logic rst_n,
	input monitor_char_pkg::uart_byte_t rout,
	input logic rout_en,
	input logic dump_running,
	input monitor_cmd_pkg::word_t pc_data,
	input logic cpu_run_state,
	output monitor_cmd_pkg::word_t uart_data,
	output logic cpu_start,
	output logic write_address_set,
	output logic write_data_en,
	output logic read_start_set,
	output logic read_end_set,
	output logic read_stop,
	output logic quit_cmd,
	output logic crlf_in
);

	logic bp_load;
	logic bp_hit;

	char_bus_if chr ();
	word_bus_if wbus ();

	char_decoder u_decoder (
		.clk (clk),
		.rst_n (rst_n),
		.rout (rout),
		.rout_en (rout_en),
		.chr (chr.source)
	);

	hex_word_collector u_collector (
		.clk (clk),
		.rst_n (rst_n),
		.chr (chr.sink),
		.wbus (wbus.store)
	);

	cmd_sequencer u_sequencer (
		.clk (clk),
		.rst_n (rst_n),
		.chr (chr.sink),
		.wbus (wbus.ctrl),
		.dump_running (dump_running),
		.cpu_run_state (cpu_run_state),
		.bp_hit (bp_hit),
		.bp_load (bp_load),
		.cpu_start (cpu_start),
		.write_address_set (write_address_set),
		.write_data_en (write_data_en),
		.read_start_set (read_start_set),
		.read_end_set (read_end_set),
		.read_stop (read_stop),
		.quit_cmd (quit_cmd),
		.crlf_in (crlf_in)
	);

	// breakpoint takes its address from the collected word
	pc_breakpoint u_breakpoint (
		.clk (clk),
		.rst_n (rst_n),
		.bp_load (bp_load),
		.word (wbus.word),
		.pc_data (pc_data),
		.cpu_run_state (cpu_run_state),
		.hit (bp_hit)
	);

	assign uart_data = wbus.word;

endmodule

// ==== hdl/pc_breakpoint.sv ====
`timescale 1ns/1ps

module pc_breakpoint (
	input logic clk,
	input logic rst_n,
	input logic bp_load,
	input monitor_cmd_pkg::word_t word,
	input monitor_cmd_pkg::word_t pc_data,
	input logic cpu_run_state,
	output logic hit
);
	import monitor_cmd_pkg::*;

	bp_addr_t bp_addr;
	logic armed;

	always_ff @(posedge clk) begin
		if (bp_load)
			bp_addr <= word[31:2];
	end

	// bit 0 set in the s word disarms
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			armed <= 1'b0;
		else if (bp_load)
			armed <= ~word[0];
	end

	// compare the word address only
	assign hit = armed & (bp_addr == pc_data[31:2]) & cpu_run_state;

endmodule

// ==== hdl/cmd_sequencer.sv ====
`timescale 1ns/1ps

module cmd_sequencer (
	input logic clk,
	input logic rst_n,
	char_bus_if.sink chr,
	word_bus_if.ctrl wbus,
	input logic dump_running,
	input logic cpu_run_state,
	input logic bp_hit,
	output logic bp_load,
	output logic cpu_start,
	output logic write_address_set,
	output logic write_data_en,
	output logic read_start_set,
	output logic read_end_set,
	output logic read_stop,
	output logic quit_cmd,
	output logic crlf_in
);
	import monitor_cmd_pkg::*;

	cmd_state_t state;
	cmd_state_t state_nxt;

	logic quit_key;
	logic cr_key;
	logic cmd_key;
	logic digit_key;
	logic arg_state;
	logic last_word;
	logic go_crlf;
	logic run_stop;
	logic [START_DELAY-1:0] go_dly;

	// keys only count in their strobe cycle
	assign quit_key = chr.strobe & chr.is_quit;
	assign cr_key = chr.strobe & chr.is_cr;
	assign cmd_key = chr.strobe & (chr.cmd != CMD_NONE);
	assign digit_key = chr.strobe & chr.is_digit;

	// breakpoint stops only a running cpu
	assign run_stop = bp_hit & cpu_run_state;

	always_comb begin
		state_nxt = state;
		if (quit_key) begin
			state_nxt = ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (cmd_key) begin
						case (chr.cmd)
							CMD_GO:
								state_nxt = ST_GO_ADDR;
							CMD_WRITE:
								state_nxt = ST_WR_ADDR;
							CMD_READ:
								state_nxt = ST_RD_START;
							CMD_STOP_SET:
								state_nxt = ST_STOP_ADDR;
							default:
								state_nxt = ST_IDLE;
						endcase
					end
				end
				ST_GO_ADDR:
					if (wbus.word_valid)
						state_nxt = ST_GO_RUN;
				ST_GO_RUN:
					if (run_stop)
						state_nxt = ST_IDLE;
				ST_WR_ADDR:
					if (wbus.word_valid)
						state_nxt = ST_WR_DATA;
				// data words keep coming until ctrl-c
				ST_WR_DATA:
					state_nxt = ST_WR_DATA;
				ST_RD_START:
					if (wbus.word_valid)
						state_nxt = ST_RD_END;
				ST_RD_END:
					if (wbus.word_valid)
						state_nxt = ST_RD_DUMP;
				ST_RD_DUMP:
					if (!dump_running)
						state_nxt = ST_IDLE;
				ST_STOP_ADDR:
					if (wbus.word_valid)
						state_nxt = ST_IDLE;
				default:
					state_nxt = ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= ST_IDLE;
		else
			state <= state_nxt;
	end

	// states that collect argument digits
	assign arg_state = state inside {ST_GO_ADDR, ST_WR_ADDR, ST_WR_DATA,
		ST_RD_START, ST_RD_END, ST_STOP_ADDR};

	assign wbus.take_digit = digit_key & arg_state;
	// new command or quit restarts the word
	assign wbus.clear = quit_key | ((state == ST_IDLE) & cmd_key);

	// last argument word of a command
	assign last_word = wbus.word_valid &
		(state inside {ST_GO_ADDR, ST_WR_ADDR, ST_RD_END, ST_STOP_ADDR});
	assign go_crlf = wbus.word_valid & (state == ST_GO_ADDR);

	// cpu start trails the go line break
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			go_dly <= '0;
		else
			go_dly <= {go_dly[START_DELAY-2:0], go_crlf};
	end

	assign cpu_start = go_dly[START_DELAY-1];

	assign bp_load = wbus.word_valid & (state == ST_STOP_ADDR);
	assign write_address_set = wbus.word_valid & (state == ST_WR_ADDR);
	assign write_data_en = wbus.word_valid & (state == ST_WR_DATA);
	assign read_start_set = wbus.word_valid & (state == ST_RD_START);
	assign read_end_set = wbus.word_valid & (state == ST_RD_END);
	assign read_stop = quit_key & (state == ST_RD_DUMP);
	assign quit_cmd = quit_key | run_stop;
	assign crlf_in = quit_key | cr_key | last_word;

endmodule

// ==== hdl/hex_word_collector.sv ====
`timescale 1ns/1ps

module hex_word_collector (
	input logic clk,
	input logic rst_n,
	char_bus_if.sink chr,
	word_bus_if.store wbus
);
	import monitor_cmd_pkg::*;

	typedef logic [$clog2(DIGITS_PER_WORD)-1:0] digit_cnt_t;

	word_t acc;
	word_t acc_nxt;
	digit_cnt_t cnt;
	logic last_digit;

	// new digit enters at the low nibble
	assign acc_nxt = {acc[27:0], chr.digit};
	assign last_digit = wbus.take_digit && (cnt == digit_cnt_t'(DIGITS_PER_WORD - 1));

	// partial word
	always_ff @(posedge clk) begin
		if (wbus.clear)
			acc <= '0;
		else if (wbus.take_digit)
			acc <= acc_nxt;
	end

	// digit count wraps straight to zero after the last digit
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (wbus.clear) begin
			cnt <= '0;
		end else if (last_digit) begin
			cnt <= '0;
		end else if (wbus.take_digit) begin
			cnt <= cnt + 1'b1;
		end
	end

	// completed word and its one-cycle valid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wbus.word_valid <= 1'b0;
			wbus.word <= '0;
		end else begin
			wbus.word_valid <= last_digit;
			if (last_digit)
				wbus.word <= acc_nxt;
		end
	end

endmodule

// ==== hdl/char_decoder.sv ====
`timescale 1ns/1ps

module char_decoder (
	input logic clk,
	input logic rst_n,
	input monitor_char_pkg::uart_byte_t rout,
	input logic rout_en,
	char_bus_if.source chr
);
	import monitor_char_pkg::*;
	import monitor_cmd_pkg::*;

	uart_byte_t byte_q;
	logic is_num;
	logic is_hex_letter;

	// capture the byte as it arrives
	always_ff @(posedge clk) begin
		if (rout_en)
			byte_q <= rout;
	end

	// strobe lines up with the registered byte
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			chr.strobe <= 1'b0;
		else
			chr.strobe <= rout_en;
	end

	assign is_num = (byte_q >= CHAR_ZERO) && (byte_q <= CHAR_NINE);
	assign is_hex_letter = (byte_q >= CHAR_LOWER_A) && (byte_q <= CHAR_LOWER_F);

	always_comb begin
		chr.is_digit = is_num | is_hex_letter;
		// a..f carry 1..6 in the low nibble
		if (is_num)
			chr.digit = byte_q[3:0];
		else
			chr.digit = nibble_t'(byte_q[3:0] + 4'd9);
		chr.is_quit = (byte_q == CHAR_CTRL_C);
		chr.is_cr = (byte_q == CHAR_CR);
	end

	// command letters
	always_comb begin
		case (byte_q)
			CHAR_G:
				chr.cmd = CMD_GO;
			CHAR_W:
				chr.cmd = CMD_WRITE;
			CHAR_R:
				chr.cmd = CMD_READ;
			CHAR_S:
				chr.cmd = CMD_STOP_SET;
			default:
				chr.cmd = CMD_NONE;
		endcase
	end

endmodule

// ==== hdl/word_bus_if.sv ====
`timescale 1ns/1ps

interface word_bus_if;
	import monitor_cmd_pkg::*;

	// digit shift request and restart of the word
	logic take_digit;
	logic clear;

	// completed word, held until the next one
	logic word_valid;
	word_t word;

	modport ctrl (
		output take_digit, clear,
		input word_valid
	);

	modport store (
		input take_digit, clear,
		output word_valid, word
	);

endinterface

// ==== hdl/char_bus_if.sv ====
`timescale 1ns/1ps

interface char_bus_if;
	import monitor_char_pkg::*;
	import monitor_cmd_pkg::*;

	// fields other than strobe only count while strobe is high
	logic strobe;
	logic is_digit;
	nibble_t digit;
	cmd_code_t cmd;
	logic is_quit;
	logic is_cr;

	modport source (
		output strobe, is_digit, digit, cmd, is_quit, is_cr
	);

	modport sink (
		input strobe, is_digit, digit, cmd, is_quit, is_cr
	);

endinterface

// ==== hdl/monitor_cmd_pkg.sv ====
package monitor_cmd_pkg;

	// address or data word
	typedef logic [31:0] word_t;

	// word-aligned breakpoint address in bits 31:2
	typedef logic [31:2] bp_addr_t;

	// class of a command letter
	typedef logic [2:0] cmd_code_t;

	localparam cmd_code_t CMD_NONE = 3'd0;
	localparam cmd_code_t CMD_GO = 3'd1;
	localparam cmd_code_t CMD_WRITE = 3'd2;
	localparam cmd_code_t CMD_READ = 3'd3;
	localparam cmd_code_t CMD_STOP_SET = 3'd4;

	// hex digits in one argument word
	localparam int DIGITS_PER_WORD = 8;

	// cycles from the go line break to cpu_start
	localparam int START_DELAY = 3;

	// command state machine
	typedef enum logic [3:0] {
		ST_IDLE,
		// g <addr>
		ST_GO_ADDR,
		ST_GO_RUN,
		// w <addr> <data> ... ctrl-c
		ST_WR_ADDR,
		ST_WR_DATA,
		// r <start> <end>
		ST_RD_START,
		ST_RD_END,
		ST_RD_DUMP,
		// s <addr>
		ST_STOP_ADDR
	} cmd_state_t;

endpackage

// ==== hdl/monitor_char_pkg.sv ====
package monitor_char_pkg;

	// one received character
	typedef logic [7:0] uart_byte_t;

	// value of a single hex digit
	typedef logic [3:0] nibble_t;

	// control characters
	localparam uart_byte_t CHAR_CTRL_C = 8'h03;
	localparam uart_byte_t CHAR_CR = 8'h0d;

	// command letters
	localparam uart_byte_t CHAR_G = 8'h67;
	localparam uart_byte_t CHAR_W = 8'h77;
	localparam uart_byte_t CHAR_R = 8'h72;
	localparam uart_byte_t CHAR_S = 8'h73;

	// hex digit ranges in lower case only
	localparam uart_byte_t CHAR_ZERO = 8'h30;
	localparam uart_byte_t CHAR_NINE = 8'h39;
	localparam uart_byte_t CHAR_LOWER_A = 8'h61;
	localparam uart_byte_t CHAR_LOWER_F = 8'h66;

endpackage
